//--- all.f
common/dcachePkg.sv
cacheWay/cacheWay.sv
source/dcacheCtrl.sv
source/respMerge.sv
source/dcacheTop.sv
sim/tbClock.sv
sim/dcache_assertions.sv
sim/dcacheTb.sv

//--- run.sh
#!/usr/bin/env bash
# Compile and run the data cache testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module dcacheTb -f all.f -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "Verilator compile failed"
  exit 1
fi

./obj_dir/VdcacheTb +verilator+error+limit+1000 > sim.log 2>&1
simStatus=$?
cat sim.log
if [ $simStatus -ne 0 ]; then
  echo "Simulation exited with status $simStatus"
  exit 1
fi

if grep -qx "No errors" sim.log; then
  echo "PASS"
  exit 0
else
  echo "FAIL"
  exit 1
fi

//--- sim/dcacheTb.sv
`default_nettype none

module dcacheTb;
  import dcachePkg::*;

  localparam int NUM_REQ = 400;
  localparam int CYCLE_LIMIT = NUM_REQ * 40;
  localparam logic [TAG_W-1:0] TAG_BASE = TAG_W'('h1a5);

  logic                clk;
  logic                rst_n;
  logic                reqValid_i;
  logic                reqWrite_i;
  logic [ADDR_W-1:0]   reqAddr_i;
  logic [DATA_W-1:0]   reqWrData_i;
  logic [MASK_W-1:0]   reqWrMask_i;
  logic                reqReady_o;
  logic                respValid_o;
  logic [DATA_W-1:0]   respRdData_o;
  logic                respReady_i;
  logic                memRdReqValid_o;
  logic [ADDR_W-1:0]   memRdAddr_o;
  logic                memRdReqReady_i;
  logic                memRdDataValid_i;
  logic [DATA_W-1:0]   memRdData_i;
  logic                memWrValid_o;
  logic [ADDR_W-1:0]   memWrAddr_o;
  logic [LINE_W-1:0]   memWrData_o;
  logic                memWrReady_i;

  integer seed = 64;
  int errors = 0;
  int checks = 0;
  int cycles = 0;

  // handshake counts seen by the monitor
  int rdCount;
  int wbCount;
  int respCount;
  logic [ADDR_W-1:0]   rdAddrSeen;
  logic [ADDR_W-1:0]   wbAddrSeen;
  logic [LINE_W-1:0]   wbLineSeen;

  // architectural memory, backing memory and cache model
  logic [DATA_W-1:0]   archMem [logic [ADDR_W-1:0]];
  logic [DATA_W-1:0]   backMem [logic [ADDR_W-1:0]];
  logic [TAG_W-1:0]    modelTag [NUM_SETS][NUM_WAYS];
  logic                modelValid [NUM_SETS][NUM_WAYS];
  logic                modelDirty [NUM_SETS][NUM_WAYS];
  logic [NUM_SETS-1:0] modelRr;

  tbClock i_tbClock (.clk_o(clk));

  dcacheTop i_dcacheTop (.*);

  function automatic logic [DATA_W-1:0] initWord(input logic [ADDR_W-1:0] a);
    return {a ^ 32'h6c8e9cf5, ~a};
  endfunction

  function automatic logic [DATA_W-1:0] archWord(input logic [ADDR_W-1:0] a);
    return archMem.exists(a) ? archMem[a] : initWord(a);
  endfunction

  function automatic logic [DATA_W-1:0] backWord(input logic [ADDR_W-1:0] a);
    return backMem.exists(a) ? backMem[a] : initWord(a);
  endfunction

  function automatic logic [LINE_W-1:0] archLine(input logic [ADDR_W-1:0] base);
    logic [LINE_W-1:0] line;
    int k;
    for (k = 0; k < BEATS; k++) begin
      line[k*DATA_W +: DATA_W] = archWord(base + k * MASK_W);
    end
    return line;
  endfunction

  task automatic compareValue(input string name, input logic [LINE_W-1:0] got,
                              input logic [LINE_W-1:0] expected);
    checks++;
    if (got !== expected) begin
      errors++;
      $display("Fail %s: got %0h, expected %0h", name, got, expected);
    end
  endtask

  // one request from drive to response, checked against the model
  task automatic issueRequest();
    logic [31:0]       rnd;
    logic [DATA_W-1:0] wrData;
    addrWord_u         addr;
    addrWord_u         lineA;
    addrWord_u         wordA;
    addrWord_u         wbA;
    logic [INDEX_W-1:0] set;
    logic              isMiss;
    logic              hitWay;
    logic              victim;
    logic              wbExpected;
    logic [LINE_W-1:0] wbLineExp;
    logic [DATA_W-1:0] word;
    int                rdBase;
    int                wbBase;
    int                b;
    rnd = $random(seed);
    wrData[31:0] = $random(seed);
    wrData[63:32] = $random(seed);
    addr.fields.tag = TAG_BASE + TAG_W'(rnd[7:0] % 3);
    addr.fields.index = INDEX_W'(rnd[9:8]);
    addr.fields.wordSel = rnd[11:10];
    addr.fields.byteSel = rnd[14:12];
    @(negedge clk);
    reqValid_i = 1'b1;
    reqWrite_i = rnd[15];
    reqWrMask_i = rnd[23:16];
    reqAddr_i = addr.raw;
    reqWrData_i = wrData;
    do @(posedge clk); while (!reqReady_o);
    rdBase = rdCount;
    wbBase = wbCount;

    // predict hit, victim and write-back
    set = addr.fields.index;
    isMiss = 1'b1;
    hitWay = 1'b0;
    for (b = 0; b < NUM_WAYS; b++) begin
      if (modelValid[set][b] && modelTag[set][b] == addr.fields.tag) begin
        isMiss = 1'b0;
        hitWay = b[0];
      end
    end
    victim = modelRr[set];
    wbExpected = isMiss && modelValid[set][victim] && modelDirty[set][victim];
    wbA = addr;
    wbA.fields.tag = modelTag[set][victim];
    wbA.fields.wordSel = '0;
    wbA.fields.byteSel = '0;
    wbLineExp = archLine(wbA.raw);
    lineA = addr;
    lineA.fields.wordSel = '0;
    lineA.fields.byteSel = '0;
    wordA = addr;
    wordA.fields.byteSel = '0;
    if (isMiss) begin
      modelTag[set][victim] = addr.fields.tag;
      modelValid[set][victim] = 1'b1;
      modelDirty[set][victim] = 1'b0;
      modelRr[set] = ~modelRr[set];
      hitWay = victim;
    end
    if (reqWrite_i) begin
      word = archWord(wordA.raw);
      for (b = 0; b < MASK_W; b++) begin
        if (reqWrMask_i[b]) begin
          word[b*8 +: 8] = reqWrData_i[b*8 +: 8];
        end
      end
      archMem[wordA.raw] = word;
      modelDirty[set][hitWay] = 1'b1;
    end

    @(negedge clk);
    reqValid_i = 1'b0;
    // response may still wait for ready while the next request is offered
    do @(posedge clk); while (!respValid_o);
    if (!reqWrite_i) begin
      compareValue("respRdData_o", LINE_W'(respRdData_o), LINE_W'(archWord(wordA.raw)));
    end
    compareValue("memRdReqValid_o count", LINE_W'(rdCount - rdBase), LINE_W'(isMiss));
    if (isMiss) begin
      compareValue("memRdAddr_o", LINE_W'(rdAddrSeen), LINE_W'(lineA.raw));
    end
    compareValue("memWrValid_o count", LINE_W'(wbCount - wbBase), LINE_W'(wbExpected));
    if (wbExpected) begin
      compareValue("memWrAddr_o", LINE_W'(wbAddrSeen), LINE_W'(wbA.raw));
      compareValue("memWrData_o", wbLineSeen, wbLineExp);
    end
  endtask

  initial begin
    rst_n = 1'b0;
    reqValid_i = 1'b0;
    reqWrite_i = 1'b0;
    reqAddr_i = '0;
    reqWrData_i = '0;
    reqWrMask_i = '0;
    for (int s = 0; s < NUM_SETS; s++) begin
      for (int w = 0; w < NUM_WAYS; w++) begin
        modelTag[s][w] = '0;
        modelValid[s][w] = 1'b0;
        modelDirty[s][w] = 1'b0;
      end
    end
    modelRr = '0;
    repeat (16) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    @(posedge clk);
    for (int n = 0; n < NUM_REQ; n++) begin
      issueRequest();
    end
    // last response drains under back-pressure
    while (respCount < NUM_REQ) begin
      @(posedge clk);
    end
    repeat (10) @(posedge clk);
    compareValue("respValid_o count", LINE_W'(respCount), LINE_W'(NUM_REQ));
    errors += i_dcacheTop.i_dcacheAssertions.respFails;
    errors += i_dcacheTop.i_dcacheAssertions.rdFails;
    errors += i_dcacheTop.i_dcacheAssertions.wrFails;
    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

  // memory side, ready after 0 to 3 cycles, beats with random gaps
  // response ready about three cycles in four
  initial begin : memResponder
    logic [31:0]       rnd;
    logic [1:0]        rdDelay;
    logic [1:0]        wrDelay;
    int                beatsLeft;
    logic [ADDR_W-1:0] beatAddr;
    respReady_i = 1'b0;
    memRdReqReady_i = 1'b0;
    memRdDataValid_i = 1'b0;
    memRdData_i = '0;
    memWrReady_i = 1'b0;
    rdDelay = '0;
    wrDelay = '0;
    beatsLeft = 0;
    beatAddr = '0;
    forever begin
      @(negedge clk);
      rnd = $random(seed);
      respReady_i = (rnd[7:6] != 2'b00);
      memRdDataValid_i = 1'b0;
      if (memRdReqReady_i) begin
        memRdReqReady_i = 1'b0;
        rdDelay = rnd[1:0];
        beatsLeft = BEATS;
      end else if (memRdReqValid_o) begin
        if (rdDelay == 2'd0) begin
          memRdReqReady_i = 1'b1;
          beatAddr = memRdAddr_o;
        end else begin
          rdDelay--;
        end
      end else if (beatsLeft > 0 && rnd[3:2] != 2'b00) begin
        memRdDataValid_i = 1'b1;
        memRdData_i = backWord(beatAddr);
        beatAddr = beatAddr + MASK_W;
        beatsLeft--;
      end
      if (memWrReady_i) begin
        memWrReady_i = 1'b0;
        wrDelay = rnd[5:4];
      end else if (memWrValid_o) begin
        if (wrDelay == 2'd0) begin
          memWrReady_i = 1'b1;
          for (int k = 0; k < BEATS; k++) begin
            backMem[memWrAddr_o + k * MASK_W] = memWrData_o[k*DATA_W +: DATA_W];
          end
        end else begin
          wrDelay--;
        end
      end
    end
  end

  // handshakes as they complete at the rising edge
  initial begin
    rdCount = 0;
    wbCount = 0;
    respCount = 0;
    rdAddrSeen = '0;
    wbAddrSeen = '0;
    wbLineSeen = '0;
    forever begin
      @(posedge clk);
      if (memRdReqValid_o && memRdReqReady_i) begin
        rdCount++;
        rdAddrSeen = memRdAddr_o;
      end
      if (memWrValid_o && memWrReady_i) begin
        wbCount++;
        wbAddrSeen = memWrAddr_o;
        wbLineSeen = memWrData_o;
      end
      if (respValid_o && respReady_i) begin
        respCount++;
      end
    end
  end

  initial begin
    while (cycles < CYCLE_LIMIT) begin
      @(posedge clk);
      cycles++;
    end
    $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
    $display("%0d checks, %0d errors", checks, errors);
    $display("Errors found");
    $finish;
  end

endmodule

`default_nettype wire

//--- sim/dcache_assertions.sv
`default_nettype none

module dcache_assertions (
  input logic                                 clk,
  input logic                                 rst_n,
  input logic                                 respValid_i,
  input logic [dcachePkg::DATA_W-1:0]         respRdData_i,
  input logic                                 respReady_i,
  input logic                                 memRdReqValid_i,
  input logic [dcachePkg::ADDR_W-1:0]         memRdAddr_i,
  input logic                                 memRdReqReady_i,
  input logic                                 memWrValid_i,
  input logic [dcachePkg::ADDR_W-1:0]         memWrAddr_i,
  input logic                                 memWrReady_i
);

  int respFails = 0;
  int rdFails = 0;
  int wrFails = 0;

  // response held under back-pressure
  respHold: assert property (@(posedge clk) disable iff (!rst_n)
    respValid_i && !respReady_i |=> respValid_i && $stable(respRdData_i))
  else begin
    respFails++;
    $error("response dropped or changed before it was accepted");
  end

  rdReqHold: assert property (@(posedge clk) disable iff (!rst_n)
    memRdReqValid_i && !memRdReqReady_i |=> memRdReqValid_i && $stable(memRdAddr_i))
  else begin
    rdFails++;
    $error("memory read request dropped or changed before ready");
  end

  wrHold: assert property (@(posedge clk) disable iff (!rst_n)
    memWrValid_i && !memWrReady_i |=> memWrValid_i && $stable(memWrAddr_i))
  else begin
    wrFails++;
    $error("write-back dropped or changed before ready");
  end

endmodule

bind dcacheTop dcache_assertions i_dcacheAssertions (
  .clk             (clk),
  .rst_n           (rst_n),
  .respValid_i     (respValid_o),
  .respRdData_i    (respRdData_o),
  .respReady_i     (respReady_i),
  .memRdReqValid_i (memRdReqValid_o),
  .memRdAddr_i     (memRdAddr_o),
  .memRdReqReady_i (memRdReqReady_i),
  .memWrValid_i    (memWrValid_o),
  .memWrAddr_i     (memWrAddr_o),
  .memWrReady_i    (memWrReady_i)
);

`default_nettype wire

//--- sim/tbClock.sv
`default_nettype none

module tbClock (
  output logic clk_o
);

  // period 8
  initial begin
    clk_o = 1'b0;
    forever begin
      #4 clk_o = ~clk_o;
    end
  end

endmodule

`default_nettype wire

//--- source/dcacheTop.sv
`default_nettype none

module dcacheTop (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          reqValid_i,
  input  logic                          reqWrite_i,
  input  logic [dcachePkg::ADDR_W-1:0]  reqAddr_i,
  input  logic [dcachePkg::DATA_W-1:0]  reqWrData_i,
  input  logic [dcachePkg::MASK_W-1:0]  reqWrMask_i,
  output logic                          reqReady_o,
  output logic                          respValid_o,
  output logic [dcachePkg::DATA_W-1:0]  respRdData_o,
  input  logic                          respReady_i,
  output logic                          memRdReqValid_o,
  output logic [dcachePkg::ADDR_W-1:0]  memRdAddr_o,
  input  logic                          memRdReqReady_i,
  input  logic                          memRdDataValid_i,
  input  logic [dcachePkg::DATA_W-1:0]  memRdData_i,
  output logic                          memWrValid_o,
  output logic [dcachePkg::ADDR_W-1:0]  memWrAddr_o,
  output logic [dcachePkg::LINE_W-1:0]  memWrData_o,
  input  logic                          memWrReady_i
);
  import dcachePkg::*;

  // controller to ways
  logic [INDEX_W-1:0]                index;
  logic [TAG_W-1:0]                  tag;
  logic [NUM_WAYS-1:0]               wayWrEn;
  logic [LINE_W-1:0]                 wrLine;
  logic [LINE_BYTES-1:0]             wrByteEn;
  logic                              fill;
  logic                              storeHit;

  // ways back to controller and merger
  logic [NUM_WAYS-1:0]               wayHit;
  logic [NUM_WAYS-1:0]               wayDirty;
  logic [NUM_WAYS-1:0][TAG_W-1:0]    wayTag;
  logic [NUM_WAYS-1:0][LINE_W-1:0]   wayLine;

  // controller to merger
  logic                              respCapture;
  addrWord_u                         reqAddrQ;
  logic                              victimWay;

  dcacheCtrl i_dcacheCtrl (
    .clk              (clk),
    .rst_n            (rst_n),
    .reqValid_i       (reqValid_i),
    .reqWrite_i       (reqWrite_i),
    .reqAddr_i        (reqAddr_i),
    .reqWrData_i      (reqWrData_i),
    .reqWrMask_i      (reqWrMask_i),
    .respValid_i      (respValid_o),
    .memRdReqReady_i  (memRdReqReady_i),
    .memRdDataValid_i (memRdDataValid_i),
    .memRdData_i      (memRdData_i),
    .memWrReady_i     (memWrReady_i),
    .wayHit_i         (wayHit),
    .wayDirty_i       (wayDirty),
    .wayTag_i         (wayTag),
    .reqReady_o       (reqReady_o),
    .index_o          (index),
    .tag_o            (tag),
    .wayWrEn_o        (wayWrEn),
    .wrLine_o         (wrLine),
    .wrByteEn_o       (wrByteEn),
    .fill_o           (fill),
    .storeHit_o       (storeHit),
    .respCapture_o    (respCapture),
    .reqAddr_o        (reqAddrQ),
    .victimWay_o      (victimWay),
    .memRdReqValid_o  (memRdReqValid_o),
    .memRdAddr_o      (memRdAddr_o),
    .memWrValid_o     (memWrValid_o),
    .memWrAddr_o      (memWrAddr_o)
  );

  for (genvar w = 0; w < NUM_WAYS; w++) begin : gWay
    cacheWay i_cacheWay (
      .clk        (clk),
      .rst_n      (rst_n),
      .index_i    (index),
      .tag_i      (tag),
      .wrEn_i     (wayWrEn[w]),
      .wrLine_i   (wrLine),
      .wrByteEn_i (wrByteEn),
      .fill_i     (fill),
      .storeHit_i (storeHit),
      .hit_o      (wayHit[w]),
      .line_o     (wayLine[w]),
      .dirty_o    (wayDirty[w]),
      .tag_o      (wayTag[w])
    );
  end

  respMerge i_respMerge (
    .clk           (clk),
    .rst_n         (rst_n),
    .wayHit_i      (wayHit),
    .wayLine_i     (wayLine),
    .reqAddr_i     (reqAddrQ),
    .victimWay_i   (victimWay),
    .respCapture_i (respCapture),
    .respReady_i   (respReady_i),
    .respValid_o   (respValid_o),
    .respRdData_o  (respRdData_o),
    .memWrData_o   (memWrData_o)
  );

endmodule

`default_nettype wire

//--- source/respMerge.sv
`default_nettype none

module respMerge (
  input  logic                                                  clk,
  input  logic                                                  rst_n,
  input  logic [dcachePkg::NUM_WAYS-1:0]                        wayHit_i,
  input  logic [dcachePkg::NUM_WAYS-1:0][dcachePkg::LINE_W-1:0] wayLine_i,
  input  dcachePkg::addrWord_u                                  reqAddr_i,
  input  logic                                                  victimWay_i,
  input  logic                                                  respCapture_i,
  input  logic                                                  respReady_i,
  output logic                                                  respValid_o,
  output logic [dcachePkg::DATA_W-1:0]                          respRdData_o,
  output logic [dcachePkg::LINE_W-1:0]                          memWrData_o
);
  import dcachePkg::*;

  logic [LINE_W-1:0] hitLine;
  logic [DATA_W-1:0] hitWord;

  // at most one way hits
  always_comb begin
    hitLine = '0;
    for (int w = 0; w < NUM_WAYS; w++) begin
      if (wayHit_i[w]) begin
        hitLine = wayLine_i[w];
      end
    end
  end

  assign hitWord = hitLine[reqAddr_i.fields.wordSel * DATA_W +: DATA_W];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      respValid_o <= 1'b0;
    end else if (respCapture_i) begin
      respValid_o <= 1'b1;
    end else if (respReady_i) begin
      respValid_o <= 1'b0;
    end
  end

  // held while the response waits
  always_ff @(posedge clk) begin
    if (respCapture_i) begin
      respRdData_o <= hitWord;
    end
  end

  assign memWrData_o = wayLine_i[victimWay_i];

endmodule

`default_nettype wire

//--- source/dcacheCtrl.sv
`default_nettype none

module dcacheCtrl (
  input  logic                                                 clk,
  input  logic                                                 rst_n,
  input  logic                                                 reqValid_i,
  input  logic                                                 reqWrite_i,
  input  logic [dcachePkg::ADDR_W-1:0]                         reqAddr_i,
  input  logic [dcachePkg::DATA_W-1:0]                         reqWrData_i,
  input  logic [dcachePkg::MASK_W-1:0]                         reqWrMask_i,
  input  logic                                                 respValid_i,
  input  logic                                                 memRdReqReady_i,
  input  logic                                                 memRdDataValid_i,
  input  logic [dcachePkg::DATA_W-1:0]                         memRdData_i,
  input  logic                                                 memWrReady_i,
  input  logic [dcachePkg::NUM_WAYS-1:0]                       wayHit_i,
  input  logic [dcachePkg::NUM_WAYS-1:0]                       wayDirty_i,
  input  logic [dcachePkg::NUM_WAYS-1:0][dcachePkg::TAG_W-1:0] wayTag_i,
  output logic                                                 reqReady_o,
  output logic [dcachePkg::INDEX_W-1:0]                        index_o,
  output logic [dcachePkg::TAG_W-1:0]                          tag_o,
  output logic [dcachePkg::NUM_WAYS-1:0]                       wayWrEn_o,
  output logic [dcachePkg::LINE_W-1:0]                         wrLine_o,
  output logic [dcachePkg::LINE_BYTES-1:0]                     wrByteEn_o,
  output logic                                                 fill_o,
  output logic                                                 storeHit_o,
  output logic                                                 respCapture_o,
  output dcachePkg::addrWord_u                                 reqAddr_o,
  output logic                                                 victimWay_o,
  output logic                                                 memRdReqValid_o,
  output logic [dcachePkg::ADDR_W-1:0]                         memRdAddr_o,
  output logic                                                 memWrValid_o,
  output logic [dcachePkg::ADDR_W-1:0]                         memWrAddr_o
);
  import dcachePkg::*;

  logic [STATE_W-1:0]           state;
  logic [STATE_W-1:0]           stateNext;
  logic                         readyEn;
  logic                         reqFire;
  logic                         lookupHit;
  logic                         rrVictim;

  // latched request
  addrWord_u                    reqQ;
  logic                         writeQ;
  logic [DATA_W-1:0]            wrDataQ;
  logic [MASK_W-1:0]            wrMaskQ;

  // miss handling
  logic                         victimQ;
  logic [NUM_SETS-1:0]          rrBits;
  logic [WORD_SEL_W-1:0]        beatCnt;
  logic [BEATS-1:0][DATA_W-1:0] refillBuf;
  addrWord_u                    rdAddr;
  addrWord_u                    wrAddr;

  // held low through reset, up one clock later
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      readyEn <= 1'b0;
    end else begin
      readyEn <= 1'b1;
    end
  end

  assign reqReady_o = readyEn && (state == ST_IDLE) && !respValid_i;
  assign reqFire = reqValid_i && reqReady_o;
  assign lookupHit = |wayHit_i;
  assign rrVictim = rrBits[reqQ.fields.index];

  always_ff @(posedge clk) begin
    if (reqFire) begin
      reqQ.raw <= reqAddr_i;
      writeQ <= reqWrite_i;
      wrDataQ <= reqWrData_i;
      wrMaskQ <= reqWrMask_i;
    end
  end

  always_comb begin
    stateNext = state;
    case (state)
      ST_IDLE: begin
        if (reqFire) begin
          stateNext = ST_LOOKUP;
        end
      end
      ST_LOOKUP: begin
        if (lookupHit) begin
          stateNext = ST_IDLE;
        end else if (wayDirty_i[rrVictim]) begin
          stateNext = ST_WRITE_BACK;
        end else begin
          stateNext = ST_READ_REQ;
        end
      end
      ST_WRITE_BACK: begin
        if (memWrReady_i) begin
          stateNext = ST_READ_REQ;
        end
      end
      ST_READ_REQ: begin
        if (memRdReqReady_i) begin
          stateNext = ST_REFILL;
        end
      end
      ST_REFILL: begin
        if (memRdDataValid_i && (beatCnt == WORD_SEL_W'(BEATS - 1))) begin
          stateNext = ST_FILL;
        end
      end
      ST_FILL: begin
        // line is in place, look it up again
        stateNext = ST_LOOKUP;
      end
      default: begin
        stateNext = ST_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= ST_IDLE;
      victimQ <= 1'b0;
      rrBits <= '0;
      beatCnt <= '0;
    end else begin
      state <= stateNext;
      if (state == ST_LOOKUP && !lookupHit) begin
        victimQ <= rrVictim;
      end
      if (state == ST_FILL) begin
        rrBits[reqQ.fields.index] <= ~rrBits[reqQ.fields.index];
      end
      if (state == ST_READ_REQ) begin
        beatCnt <= '0;
      end else if (state == ST_REFILL && memRdDataValid_i) begin
        beatCnt <= beatCnt + 1'b1;
      end
    end
  end

  // refill beats, lowest word first
  always_ff @(posedge clk) begin
    if (state == ST_REFILL && memRdDataValid_i) begin
      refillBuf[beatCnt] <= memRdData_i;
    end
  end

  // store data goes to every lane, byte enables pick the lane
  always_comb begin
    wayWrEn_o = '0;
    wrLine_o = {BEATS{wrDataQ}};
    wrByteEn_o = LINE_BYTES'(wrMaskQ) << (reqQ.fields.wordSel * MASK_W);
    fill_o = 1'b0;
    storeHit_o = 1'b0;
    respCapture_o = 1'b0;
    if (state == ST_LOOKUP && lookupHit) begin
      respCapture_o = 1'b1;
      if (writeQ) begin
        wayWrEn_o = wayHit_i;
        storeHit_o = 1'b1;
      end
    end else if (state == ST_FILL) begin
      wayWrEn_o = NUM_WAYS'(1) << victimQ;
      wrLine_o = refillBuf;
      wrByteEn_o = '1;
      fill_o = 1'b1;
    end
  end

  // line-aligned memory addresses
  always_comb begin
    rdAddr = reqQ;
    rdAddr.fields.wordSel = '0;
    rdAddr.fields.byteSel = '0;
    wrAddr = rdAddr;
    wrAddr.fields.tag = wayTag_i[victimQ];
  end

  assign index_o = reqQ.fields.index;
  assign tag_o = reqQ.fields.tag;
  assign reqAddr_o = reqQ;
  assign victimWay_o = victimQ;
  assign memRdReqValid_o = (state == ST_READ_REQ);
  assign memRdAddr_o = rdAddr.raw;
  assign memWrValid_o = (state == ST_WRITE_BACK);
  assign memWrAddr_o = wrAddr.raw;

endmodule

`default_nettype wire

//--- cacheWay/cacheWay.sv
`default_nettype none

module cacheWay (
  input  logic                              clk,
  input  logic                              rst_n,
  input  logic [dcachePkg::INDEX_W-1:0]     index_i,
  input  logic [dcachePkg::TAG_W-1:0]       tag_i,
  input  logic                              wrEn_i,
  input  logic [dcachePkg::LINE_W-1:0]      wrLine_i,
  input  logic [dcachePkg::LINE_BYTES-1:0]  wrByteEn_i,
  input  logic                              fill_i,
  input  logic                              storeHit_i,
  output logic                              hit_o,
  output logic [dcachePkg::LINE_W-1:0]      line_o,
  output logic                              dirty_o,
  output logic [dcachePkg::TAG_W-1:0]       tag_o
);
  import dcachePkg::*;

  localparam int BYTE_W = LINE_W / LINE_BYTES;

  logic [TAG_W-1:0]    tagMem [NUM_SETS];
  logic [LINE_W-1:0]   dataMem [NUM_SETS];
  logic [NUM_SETS-1:0] validBits;
  logic [NUM_SETS-1:0] dirtyBits;

  // data bytes under the byte enables
  always_ff @(posedge clk) begin
    if (wrEn_i) begin
      for (int b = 0; b < LINE_BYTES; b++) begin
        if (wrByteEn_i[b]) begin
          dataMem[index_i][b*BYTE_W +: BYTE_W] <= wrLine_i[b*BYTE_W +: BYTE_W];
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (wrEn_i && fill_i) begin
      tagMem[index_i] <= tag_i;
    end
  end

  // fresh line is clean, a store marks it dirty
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      validBits <= '0;
      dirtyBits <= '0;
    end else if (wrEn_i) begin
      if (fill_i) begin
        validBits[index_i] <= 1'b1;
        dirtyBits[index_i] <= 1'b0;
      end else if (storeHit_i) begin
        dirtyBits[index_i] <= 1'b1;
      end
    end
  end

  assign tag_o = tagMem[index_i];
  assign line_o = dataMem[index_i];
  assign dirty_o = dirtyBits[index_i];
  assign hit_o = validBits[index_i] && (tagMem[index_i] == tag_i);

endmodule

`default_nettype wire

//--- common/dcachePkg.sv
`default_nettype none

package dcachePkg;

  // cpu side
  localparam int ADDR_W = 32;
  localparam int DATA_W = 64;
  localparam int MASK_W = DATA_W / 8;

  // line geometry
  localparam int LINE_W = 256;
  localparam int LINE_BYTES = LINE_W / 8;
  localparam int BEATS = LINE_W / DATA_W;

  // two ways of 64 sets
  localparam int NUM_WAYS = 2;
  localparam int NUM_SETS = 64;

  // address split
  localparam int INDEX_W = $clog2(NUM_SETS);
  localparam int WORD_SEL_W = $clog2(BEATS);
  localparam int BYTE_SEL_W = $clog2(MASK_W);
  localparam int TAG_W = ADDR_W - INDEX_W - WORD_SEL_W - BYTE_SEL_W;

  // controller FSM encoding
  localparam int STATE_W = 3;
  localparam logic [STATE_W-1:0] ST_IDLE = 3'd0;
  localparam logic [STATE_W-1:0] ST_LOOKUP = 3'd1;
  localparam logic [STATE_W-1:0] ST_WRITE_BACK = 3'd2;
  localparam logic [STATE_W-1:0] ST_READ_REQ = 3'd3;
  localparam logic [STATE_W-1:0] ST_REFILL = 3'd4;
  localparam logic [STATE_W-1:0] ST_FILL = 3'd5;

  // byte address, raw or split into its cache fields
  typedef union packed {
    logic [ADDR_W-1:0] raw;
    struct packed {
      logic [TAG_W-1:0]      tag;
      logic [INDEX_W-1:0]    index;
      logic [WORD_SEL_W-1:0] wordSel;
      logic [BYTE_SEL_W-1:0] byteSel;
    } fields;
  } addrWord_u;

endpackage

`default_nettype wire
